// File: bench/l2_cache_patterns.txt
# Request: name op strand addr mask has_fill chain data fill_data (op 0 LD 1 ST 2 LDS 3 STS)
# Expect: status sync_ok l1_holders wb_valid wb_addr line wb_line (all fields hex)
load_miss 0 0 0120 0000 0 0 0 0
0 0 0 0 0000 0 0
load_fill 0 0 0120 0000 1 0 0 00112233445566778899aabbccddeeff
1 0 0 0 0000 00112233445566778899aabbccddeeff 0
store_hit 1 0 0120 00f0 0 0 deadbeefcafebabe0123456789abcdef 0
1 0 1 0 0000 001122334455667701234567ccddeeff 0
load_core1 0 2 0120 0000 0 0 0 0
1 0 1 0 0000 001122334455667701234567ccddeeff 0
load_both 0 1 0120 0000 0 0 0 0
1 0 3 0 0000 001122334455667701234567ccddeeff 0
# Fill the other three ways of set 0
fill_way1 1 0 0230 0000 1 0 0 11111111111111111111111111111111
1 0 0 0 0000 11111111111111111111111111111111 0
fill_way2 1 0 0340 0000 1 0 0 22222222222222222222222222222222
1 0 0 0 0000 22222222222222222222222222222222 0
fill_way3 1 0 0450 0000 1 0 0 33333333333333333333333333333333
1 0 0 0 0000 33333333333333333333333333333333 0
victim_wb 0 0 0560 0000 0 0 0 0
0 0 0 1 0120 0 001122334455667701234567ccddeeff
victim_fill 0 0 0560 0000 1 0 0 55555555555555555555555555555555
1 0 0 0 0000 55555555555555555555555555555555 0
# Reservations on line 0a21
sync_load 2 1 0a21 0000 1 0 0 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
1 0 0 0 0000 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 0
sync_store 3 1 0a21 000f 0 0 ffffffffffffffffffffffffffffffff 0
1 1 1 0 0000 0f0f0f0f0f0f0f0f0f0f0f0fffffffff 0
sync_reload 2 1 0a21 0000 0 0 0 0
1 0 1 0 0000 0f0f0f0f0f0f0f0f0f0f0f0fffffffff 0
other_store 1 2 0a21 f000 0 0 12121212000000000000000000000000 0
1 0 1 0 0000 121212120f0f0f0f0f0f0f0fffffffff 0
sync_fail 3 1 0a21 ffff 0 0 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 0
1 0 1 0 0000 121212120f0f0f0f0f0f0f0fffffffff 0
after_fail 0 1 0a21 0000 0 0 0 0
1 0 1 0 0000 121212120f0f0f0f0f0f0f0fffffffff 0
# Back to back fills in sets 2 to 6
burst_fill2 0 0 1002 0000 1 1 0 02020202020202020202020202020202
1 0 0 0 0000 02020202020202020202020202020202 0
burst_fill3 0 0 1003 0000 1 1 0 03030303030303030303030303030303
1 0 0 0 0000 03030303030303030303030303030303 0
burst_fill4 0 0 1004 0000 1 1 0 04040404040404040404040404040404
1 0 0 0 0000 04040404040404040404040404040404 0
burst_fill5 0 0 1005 0000 1 1 0 05050505050505050505050505050505
1 0 0 0 0000 05050505050505050505050505050505 0
burst_fill6 0 0 1006 0000 1 0 0 06060606060606060606060606060606
1 0 0 0 0000 06060606060606060606060606060606 0
# Back to back hits from core 1
burst_hit2 0 2 1002 0000 0 1 0 0
1 0 1 0 0000 02020202020202020202020202020202 0
burst_hit3 0 2 1003 0000 0 1 0 0
1 0 1 0 0000 03030303030303030303030303030303 0
burst_hit4 0 2 1004 0000 0 1 0 0
1 0 1 0 0000 04040404040404040404040404040404 0
burst_hit5 0 2 1005 0000 0 1 0 0
1 0 1 0 0000 05050505050505050505050505050505 0
burst_hit6 0 2 1006 0000 0 0 0 0
1 0 1 0 0000 06060606060606060606060606060606 0

// File: l2_cache.f
logic/l2_config_pkg.sv
logic/l2_req_pkg.sv
logic/l2_stage_if.sv
logic/l2_tag_stage.sv
logic/l2_dir_stage.sv
logic/l2_read_stage.sv
logic/l2_update_stage.sv
logic/l2_cache_top.sv
bench/l2_clock_gen.sv
bench/l2_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f l2_cache.f --top-module l2_cache_tb -o l2_cache_sim \
	&& ./obj_dir/l2_cache_sim \
	|| exit 1

// File: bench/l2_cache_tb.sv
// L2 cache testbench with pattern reader, request driver, response monitor and compare tasks
`default_nettype none

module l2_cache_tb;
	localparam int NUM_CORES = 2;
	localparam int STRANDS_PER_CORE = 2;
	localparam int STRAND_BITS = 2;
	localparam int LINE_BITS = l2_config_pkg::LINE_BITS;
	localparam int MASK_BITS = l2_config_pkg::MASK_BITS;
	localparam int MAX_PATTERNS = 64;
	localparam int WAIT_LIMIT = 200;
	localparam int DRIVE_DELAY = 10;
	localparam logic [31:0] SEED = 32'h56fd_1b78;

	logic clk;
	logic arst_n;
	logic stall;
	logic req_valid;
	l2_req_pkg::op_e req_op;
	logic [STRAND_BITS-1:0] req_strand;
	l2_req_pkg::line_addr_u req_address;
	logic [LINE_BITS-1:0] req_data;
	logic [MASK_BITS-1:0] req_mask;
	logic req_has_fill;
	logic [LINE_BITS-1:0] req_fill_data;
	logic resp_valid;
	l2_req_pkg::op_e resp_op;
	logic [STRAND_BITS-1:0] resp_strand;
	l2_req_pkg::line_addr_u resp_address;
	l2_req_pkg::status_e resp_status;
	logic [LINE_BITS-1:0] resp_line;
	logic resp_sync_ok;
	logic [NUM_CORES-1:0] resp_l1_holders;
	logic resp_wb_valid;
	l2_req_pkg::line_addr_u resp_wb_address;
	logic [LINE_BITS-1:0] resp_wb_line;

	// One entry per pattern record
	string pat_name [MAX_PATTERNS];
	l2_req_pkg::op_e pat_op [MAX_PATTERNS];
	logic [STRAND_BITS-1:0] pat_strand [MAX_PATTERNS];
	l2_req_pkg::line_addr_u pat_addr [MAX_PATTERNS];
	logic [MASK_BITS-1:0] pat_mask [MAX_PATTERNS];
	logic pat_has_fill [MAX_PATTERNS];
	logic pat_chain [MAX_PATTERNS];
	logic [LINE_BITS-1:0] pat_data [MAX_PATTERNS];
	logic [LINE_BITS-1:0] pat_fill [MAX_PATTERNS];
	l2_req_pkg::status_e pat_status [MAX_PATTERNS];
	logic pat_sync [MAX_PATTERNS];
	logic [NUM_CORES-1:0] pat_holders [MAX_PATTERNS];
	logic pat_wb [MAX_PATTERNS];
	l2_req_pkg::line_addr_u pat_wb_addr [MAX_PATTERNS];
	logic [LINE_BITS-1:0] pat_line [MAX_PATTERNS];
	logic [LINE_BITS-1:0] pat_wb_line [MAX_PATTERNS];

	int expect_q [$];
	int checked;
	logic fresh;

	l2_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) clock_gen_i (.clk, .arst_n);

	l2_cache_top #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) dut_i (
		.clk, .arst_n, .stall,
		.req_valid, .req_op, .req_strand, .req_address,
		.req_data, .req_mask, .req_has_fill, .req_fill_data,
		.resp_valid, .resp_op, .resp_strand, .resp_address, .resp_status,
		.resp_line, .resp_sync_ok, .resp_l1_holders,
		.resp_wb_valid, .resp_wb_address, .resp_wb_line
	);

	task automatic give_up(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_status(input string name, input l2_req_pkg::status_e exp,
		input l2_req_pkg::status_e act);
		if (exp !== act)
		begin
			$display("[FAIL] %s status: expected %s, actual %s", name, exp.name(), act.name());
			give_up("response status mismatch");
		end
	endtask

	task automatic check_op(input string name, input l2_req_pkg::op_e exp,
		input l2_req_pkg::op_e act);
		if (exp !== act)
		begin
			$display("[FAIL] %s op: expected %s, actual %s", name, exp.name(), act.name());
			give_up("response operation mismatch");
		end
	endtask

	task automatic check_strand(input string name, input logic [STRAND_BITS-1:0] exp,
		input logic [STRAND_BITS-1:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s strand: expected %0d, actual %0d", name, exp, act);
			give_up("response strand mismatch");
		end
	endtask

	task automatic check_line(input string name, input string field,
		input logic [LINE_BITS-1:0] exp, input logic [LINE_BITS-1:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
			give_up("response line mismatch");
		end
	endtask

	task automatic check_holders(input string name, input logic [NUM_CORES-1:0] exp,
		input logic [NUM_CORES-1:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s l1_holders: expected %b, actual %b", name, exp, act);
			give_up("L1 holder mask mismatch");
		end
	endtask

	task automatic check_flag(input string name, input string field, input logic exp,
		input logic act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s: expected %b, actual %b", name, field, exp, act);
			give_up("response flag mismatch");
		end
	endtask

	task automatic check_address(input string name, input string field,
		input l2_req_pkg::line_addr_u exp, input l2_req_pkg::line_addr_u act);
		if (exp !== act)
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
			give_up("response address mismatch");
		end
	endtask

	function automatic logic [LINE_BITS-1:0] hex_value(input string tok);
		logic [LINE_BITS-1:0] v;
		v = '0;
		void'($sscanf(tok, "%h", v));
		return v;
	endfunction

	// Reads whitespace separated tokens and skips lines starting with #
	task automatic next_token(input int fd, output string tok);
		string rest;
		int n;
		tok = "";
		n = $fscanf(fd, "%s", tok);
		while (n == 1 && tok.substr(0, 0) == "#")
		begin
			n = $fgets(rest, fd);
			n = $fscanf(fd, "%s", tok);
		end
		if (n != 1)
			tok = "";
	endtask

	task automatic load_patterns(output int count);
		int fd;
		string tok;
		string f [15];
		logic [LINE_BITS-1:0] v [15];
		count = 0;
		fd = $fopen("bench/l2_cache_patterns.txt", "r");
		if (fd == 0)
			give_up("cannot open the pattern file");
		next_token(fd, tok);
		while (tok != "")
		begin
			if (count == MAX_PATTERNS)
				give_up("too many records in the pattern file");
			for (int k = 0; k < 15; k++)
			begin
				next_token(fd, f[k]);
				if (f[k] == "")
					give_up("pattern file ends in the middle of a record");
				v[k] = hex_value(f[k]);
			end
			pat_name[count] = tok;
			pat_op[count] = l2_req_pkg::op_e'(v[0][1:0]);
			pat_strand[count] = v[1][STRAND_BITS-1:0];
			pat_addr[count] = v[2][l2_config_pkg::ADDR_BITS-1:0];
			pat_mask[count] = v[3][MASK_BITS-1:0];
			pat_has_fill[count] = v[4][0];
			pat_chain[count] = v[5][0];
			pat_data[count] = v[6];
			pat_fill[count] = v[7];
			pat_status[count] = l2_req_pkg::status_e'(v[8][0]);
			pat_sync[count] = v[9][0];
			pat_holders[count] = v[10][NUM_CORES-1:0];
			pat_wb[count] = v[11][0];
			pat_wb_addr[count] = v[12][l2_config_pkg::ADDR_BITS-1:0];
			pat_line[count] = v[13];
			pat_wb_line[count] = v[14];
			count++;
			next_token(fd, tok);
		end
		$fclose(fd);
	endtask

	// Outputs only move on an edge where stall was low
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			fresh <= 1'b0;
		else
			fresh <= !stall;
	end

	task automatic check_response();
		int idx;
		string name;
		if (expect_q.size() == 0)
			give_up("a response arrived with no request outstanding");
		idx = expect_q.pop_front();
		name = pat_name[idx];
		check_op(name, pat_op[idx], resp_op);
		check_strand(name, pat_strand[idx], resp_strand);
		check_address(name, "address", pat_addr[idx], resp_address);
		check_status(name, pat_status[idx], resp_status);
		if (pat_status[idx] == l2_req_pkg::ST_HIT)
			check_line(name, "line", pat_line[idx], resp_line);
		if (pat_op[idx] == l2_req_pkg::OP_STORE_SYNC)
			check_flag(name, "sync_ok", pat_sync[idx], resp_sync_ok);
		check_holders(name, pat_holders[idx], resp_l1_holders);
		check_flag(name, "wb_valid", pat_wb[idx], resp_wb_valid);
		if (pat_wb[idx])
		begin
			check_address(name, "wb_address", pat_wb_addr[idx], resp_wb_address);
			check_line(name, "wb_line", pat_wb_line[idx], resp_wb_line);
		end
		checked++;
	endtask

	always @(negedge clk)
	begin
		if (arst_n && fresh && resp_valid)
			check_response();
	end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Freezes the pipeline for one to three cycles
	task automatic stall_pulse();
		stall = 1'b1;
		repeat ($urandom_range(1, 3)) next_cycle();
		stall = 1'b0;
	endtask

	// Idle cycles or a stall pulse with no request offered
	task automatic insert_gap();
		int sel;
		sel = $urandom_range(0, 3);
		if (sel == 2)
			repeat ($urandom_range(1, 2)) next_cycle();
		else if (sel == 3)
			stall_pulse();
	endtask

	task automatic send_request(input int i);
		req_valid = 1'b1;
		req_op = pat_op[i];
		req_strand = pat_strand[i];
		req_address = pat_addr[i];
		req_data = pat_data[i];
		req_mask = pat_mask[i];
		req_has_fill = pat_has_fill[i];
		req_fill_data = pat_fill[i];
		expect_q.push_back(i);
		next_cycle();
		req_valid = 1'b0;
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0)
		begin
			if (cycles == WAIT_LIMIT)
				give_up("timed out waiting for a response");
			next_cycle();
			cycles++;
		end
	endtask

	task automatic wait_reset();
		int cycles;
		cycles = 0;
		while (!arst_n)
		begin
			if (cycles == WAIT_LIMIT)
				give_up("reset was never released");
			@(posedge clk);
			cycles++;
		end
		next_cycle();
	endtask

	initial
	begin
		int count;
		stall = 1'b0;
		req_valid = 1'b0;
		req_op = l2_req_pkg::OP_LOAD;
		req_strand = '0;
		req_address = '0;
		req_data = '0;
		req_mask = '0;
		req_has_fill = 1'b0;
		req_fill_data = '0;
		checked = 0;
		void'($urandom(SEED));
		load_patterns(count);
		wait_reset();
		for (int i = 0; i < count; i++)
		begin
			insert_gap();
			send_request(i);
			// Records not chained wait for every response before the next request
			if (!pat_chain[i])
			begin
				// The tail of a burst is frozen while it is still in flight
				if (i > 0 && pat_chain[i-1])
					stall_pulse();
				drain();
			end
		end
		drain();
		if (checked == count && count > 0)
		begin
			$display("TEST PASSED");
			$finish;
		end
		else
		begin
			$display("Checked %0d responses out of %0d records", checked, count);
			$display("TEST FAILED");
			$fatal(1, "response count mismatch");
		end
	end
endmodule

`default_nettype wire

// File: bench/l2_clock_gen.sv
// Testbench clock and reset generator
`default_nettype none

module l2_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset is let go on a falling edge, away from the sampling edge
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end
endmodule

`default_nettype wire

// File: logic/l2_cache_top.sv
// L2 cache top level joining the four pipeline stages
`default_nettype none

module l2_cache_top #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2,
	localparam int TOTAL_STRANDS = NUM_CORES * STRANDS_PER_CORE,
	localparam int STRAND_BITS = (TOTAL_STRANDS > 1) ? $clog2(TOTAL_STRANDS) : 1,
	localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic req_valid,
	input l2_req_pkg::op_e req_op,
	input logic [STRAND_BITS-1:0] req_strand,
	input l2_req_pkg::line_addr_u req_address,
	input logic [l2_config_pkg::LINE_BITS-1:0] req_data,
	input logic [l2_config_pkg::MASK_BITS-1:0] req_mask,
	input logic req_has_fill,
	input logic [l2_config_pkg::LINE_BITS-1:0] req_fill_data,
	output logic resp_valid,
	output l2_req_pkg::op_e resp_op,
	output logic [STRAND_BITS-1:0] resp_strand,
	output l2_req_pkg::line_addr_u resp_address,
	output l2_req_pkg::status_e resp_status,
	output logic [l2_config_pkg::LINE_BITS-1:0] resp_line,
	output logic resp_sync_ok,
	output logic [NUM_CORES-1:0] resp_l1_holders,
	output logic resp_wb_valid,
	output l2_req_pkg::line_addr_u resp_wb_address,
	output logic [l2_config_pkg::LINE_BITS-1:0] resp_wb_line
);
	// Write-back paths from the update stage
	logic tag_wr_en;
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] tag_wr_index;
	logic [l2_config_pkg::L2_TAG_BITS-1:0] tag_wr_tag;
	logic dirty_wr_en;
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] dirty_wr_index;
	logic dirty_wr_value;
	logic l1_wr_en;
	logic [CORE_BITS-1:0] l1_wr_core;
	l2_req_pkg::line_addr_u l1_wr_address;
	logic data_wr_en;
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] data_wr_index;
	logic [l2_config_pkg::LINE_BITS-1:0] data_wr_line;
	logic [l2_config_pkg::LINE_BITS-1:0] read_line;

	l2_stage_if #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) tag_dir_if ();
	l2_stage_if #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) dir_read_if ();
	l2_stage_if #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) read_upd_if ();

	l2_tag_stage #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) tag_stage_i (
		.clk, .arst_n, .stall,
		.req_valid, .req_op, .req_strand, .req_address,
		.req_data, .req_mask, .req_has_fill, .req_fill_data,
		.tag_wr_en, .tag_wr_index, .tag_wr_tag,
		.out(tag_dir_if.producer)
	);

	l2_dir_stage #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) dir_stage_i (
		.clk, .arst_n, .stall,
		.in(tag_dir_if.consumer),
		.out(dir_read_if.producer),
		.dirty_wr_en, .dirty_wr_index, .dirty_wr_value,
		.l1_wr_en, .l1_wr_core, .l1_wr_address
	);

	l2_read_stage #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) read_stage_i (
		.clk, .arst_n, .stall,
		.in(dir_read_if.consumer),
		.out(read_upd_if.producer),
		.data_wr_en, .data_wr_index, .data_wr_line,
		.read_line
	);

	l2_update_stage #(.NUM_CORES(NUM_CORES), .STRANDS_PER_CORE(STRANDS_PER_CORE)) upd_stage_i (
		.clk, .arst_n, .stall,
		.in(read_upd_if.consumer),
		.read_line,
		.tag_wr_en, .tag_wr_index, .tag_wr_tag,
		.dirty_wr_en, .dirty_wr_index, .dirty_wr_value,
		.l1_wr_en, .l1_wr_core, .l1_wr_address,
		.data_wr_en, .data_wr_index, .data_wr_line,
		.resp_valid, .resp_op, .resp_strand, .resp_address, .resp_status,
		.resp_line, .resp_sync_ok, .resp_l1_holders,
		.resp_wb_valid, .resp_wb_address, .resp_wb_line
	);
endmodule

`default_nettype wire

// File: logic/l2_update_stage.sv
// Update stage with store merge, fill, response forming and state write-back
`default_nettype none

module l2_update_stage #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2,
	localparam int TOTAL_STRANDS = NUM_CORES * STRANDS_PER_CORE,
	localparam int STRAND_BITS = (TOTAL_STRANDS > 1) ? $clog2(TOTAL_STRANDS) : 1,
	localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	l2_stage_if.consumer in,
	input logic [l2_config_pkg::LINE_BITS-1:0] read_line,
	output logic tag_wr_en,
	output logic [l2_config_pkg::L2_INDEX_BITS-1:0] tag_wr_index,
	output logic [l2_config_pkg::L2_TAG_BITS-1:0] tag_wr_tag,
	output logic dirty_wr_en,
	output logic [l2_config_pkg::L2_INDEX_BITS-1:0] dirty_wr_index,
	output logic dirty_wr_value,
	output logic l1_wr_en,
	output logic [CORE_BITS-1:0] l1_wr_core,
	output l2_req_pkg::line_addr_u l1_wr_address,
	output logic data_wr_en,
	output logic [l2_config_pkg::L2_INDEX_BITS-1:0] data_wr_index,
	output logic [l2_config_pkg::LINE_BITS-1:0] data_wr_line,
	output logic resp_valid,
	output l2_req_pkg::op_e resp_op,
	output logic [STRAND_BITS-1:0] resp_strand,
	output l2_req_pkg::line_addr_u resp_address,
	output l2_req_pkg::status_e resp_status,
	output logic [l2_config_pkg::LINE_BITS-1:0] resp_line,
	output logic resp_sync_ok,
	output logic [NUM_CORES-1:0] resp_l1_holders,
	output logic resp_wb_valid,
	output l2_req_pkg::line_addr_u resp_wb_address,
	output logic [l2_config_pkg::LINE_BITS-1:0] resp_wb_line
);
	localparam int LINE_BITS = l2_config_pkg::LINE_BITS;

	logic is_store;
	logic present;
	logic sync_fail;
	logic do_store;
	logic do_fill;
	logic need_wb;
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] wr_index;
	logic [LINE_BITS-1:0] base_line;
	logic [LINE_BITS-1:0] merged_line;
	logic [LINE_BITS-1:0] new_line;

	assign is_store = in.op == l2_req_pkg::OP_STORE || in.op == l2_req_pkg::OP_STORE_SYNC;
	assign present = in.hit || in.has_fill;
	assign sync_fail = in.op == l2_req_pkg::OP_STORE_SYNC && !in.sync_ok;
	assign do_store = in.valid && present && is_store && !sync_fail;
	assign do_fill = in.valid && !in.hit && in.has_fill && !sync_fail;
	assign need_wb = in.valid && !present && in.victim_dirty;
	assign wr_index = {in.hit ? in.hit_way : in.victim_way, in.address.l2.set};

	// Current contents on a hit, memory data on a replayed miss
	assign base_line = in.hit ? read_line : in.fill_data;

	always_comb
	begin
		for (int b = 0; b < l2_config_pkg::MASK_BITS; b++)
			merged_line[b*8 +: 8] = in.mask[b] ? in.data[b*8 +: 8] : base_line[b*8 +: 8];
	end

	assign new_line = is_store ? merged_line : base_line;

	assign tag_wr_en = !stall && do_fill;
	assign tag_wr_index = wr_index;
	assign tag_wr_tag = in.address.l2.tag;
	// Fills by loads come in clean and anything stored is dirty
	assign dirty_wr_en = !stall && (do_store || do_fill);
	assign dirty_wr_index = wr_index;
	assign dirty_wr_value = is_store;
	assign l1_wr_en = !stall && in.valid && present && !is_store;
	assign l1_wr_core = CORE_BITS'(in.strand / STRANDS_PER_CORE);
	assign l1_wr_address = in.address;
	assign data_wr_en = dirty_wr_en;
	assign data_wr_index = wr_index;
	assign data_wr_line = new_line;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			resp_valid <= 1'b0;
			resp_wb_valid <= 1'b0;
		end
		else if (!stall)
		begin
			resp_valid <= in.valid;
			resp_wb_valid <= need_wb;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			resp_op <= in.op;
			resp_strand <= in.strand;
			resp_address <= in.address;
			resp_status <= present ? l2_req_pkg::ST_HIT : l2_req_pkg::ST_MISS;
			// A failed STORE_SYNC still shows the untouched line
			resp_line <= !present ? '0 : (sync_fail ? base_line : new_line);
			resp_sync_ok <= in.sync_ok;
			resp_l1_holders <= in.l1_holders;
			resp_wb_address.l2.tag <= in.victim_tag;
			resp_wb_address.l2.set <= in.address.l2.set;
			resp_wb_line <= read_line;
		end
	end
endmodule

`default_nettype wire

// File: logic/l2_read_stage.sv
// Data read stage with sync reservation tracking and the cache data array
`default_nettype none

module l2_read_stage #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	l2_stage_if.consumer in,
	l2_stage_if.producer out,
	input logic data_wr_en,
	input logic [l2_config_pkg::L2_INDEX_BITS-1:0] data_wr_index,
	input logic [l2_config_pkg::LINE_BITS-1:0] data_wr_line,
	output logic [l2_config_pkg::LINE_BITS-1:0] read_line
);
	localparam int TOTAL_STRANDS = NUM_CORES * STRANDS_PER_CORE;
	localparam int L2_LINES = l2_config_pkg::L2_WAYS * l2_config_pkg::L2_SETS;

	logic [l2_config_pkg::LINE_BITS-1:0] data_mem [L2_LINES];
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] read_index;
	logic [l2_config_pkg::L2_INDEX_BITS-1:0] read_index_q;

	// Reservation per strand, set by LOAD_SYNC
	l2_req_pkg::line_addr_u res_addr [TOTAL_STRANDS];
	logic [TOTAL_STRANDS-1:0] res_valid;
	logic sync_match;
	logic store_done;

	assign sync_match = res_valid[in.strand] && res_addr[in.strand] == in.address;

	// Same condition the update stage uses to actually write the line
	assign store_done = in.valid && (in.hit || in.has_fill)
		&& (in.op == l2_req_pkg::OP_STORE
		|| (in.op == l2_req_pkg::OP_STORE_SYNC && sync_match));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			res_valid <= '0;
			for (int k = 0; k < TOTAL_STRANDS; k++)
				res_addr[k] <= '0;
		end
		else if (!stall)
		begin
			if (in.valid && in.op == l2_req_pkg::OP_LOAD_SYNC)
			begin
				res_addr[in.strand] <= in.address;
				res_valid[in.strand] <= 1'b1;
			end
			if (store_done)
			begin
				// Every strand watching this line loses its reservation
				for (int k = 0; k < TOTAL_STRANDS; k++)
					if (res_addr[k] == in.address)
						res_valid[k] <= 1'b0;
			end
		end
	end

	// Hit line, or on a miss the victim that may need writing back
	assign read_index = in.hit ? {in.hit_way, in.address.l2.set}
		: {in.victim_way, in.address.l2.set};

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			read_index_q <= read_index;
			if (data_wr_en)
				data_mem[data_wr_index] <= data_wr_line;
		end
	end

	// Array latency of one cycle lines up with the update stage
	assign read_line = data_mem[read_index_q];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			out.op <= in.op;
			out.strand <= in.strand;
			out.address <= in.address;
			out.data <= in.data;
			out.mask <= in.mask;
			out.has_fill <= in.has_fill;
			out.fill_data <= in.fill_data;
			out.hit <= in.hit;
			out.hit_way <= in.hit_way;
			out.victim_way <= in.victim_way;
			out.victim_tag <= in.victim_tag;
			out.victim_dirty <= in.victim_dirty;
			out.l1_holders <= in.l1_holders;
			out.sync_ok <= sync_match;
		end
	end

	// The update stage holds its writes while the pipeline is frozen
	a_no_write_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
		stall |-> !data_wr_en);
endmodule

`default_nettype wire

// File: logic/l2_dir_stage.sv
// Directory stage with L2 dirty bits, L1 tag copies and victim dirty select
`default_nettype none

module l2_dir_stage #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2,
	localparam int CORE_BITS = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	l2_stage_if.consumer in,
	l2_stage_if.producer out,
	input logic dirty_wr_en,
	input logic [l2_config_pkg::L2_INDEX_BITS-1:0] dirty_wr_index,
	input logic dirty_wr_value,
	input logic l1_wr_en,
	input logic [CORE_BITS-1:0] l1_wr_core,
	input l2_req_pkg::line_addr_u l1_wr_address
);
	localparam int L2_LINES = l2_config_pkg::L2_WAYS * l2_config_pkg::L2_SETS;
	localparam int L1_SETS = l2_config_pkg::L1_SETS;

	logic [L2_LINES-1:0] dirty_mem;

	// One direct-mapped tag copy per core
	logic [l2_config_pkg::L1_TAG_BITS-1:0] l1_tag_mem [NUM_CORES][L1_SETS];
	logic [NUM_CORES-1:0] l1_valid_mem [L1_SETS];
	logic [NUM_CORES-1:0] holders;

	always_comb
	begin
		for (int c = 0; c < NUM_CORES; c++)
			holders[c] = l1_valid_mem[in.address.l1.set][c]
				&& l1_tag_mem[c][in.address.l1.set] == in.address.l1.tag;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dirty_mem <= '0;
			for (int s = 0; s < L1_SETS; s++)
				l1_valid_mem[s] <= '0;
		end
		else if (!stall)
		begin
			if (dirty_wr_en)
				dirty_mem[dirty_wr_index] <= dirty_wr_value;
			if (l1_wr_en)
				l1_valid_mem[l1_wr_address.l1.set][l1_wr_core] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall && l1_wr_en)
			l1_tag_mem[l1_wr_core][l1_wr_address.l1.set] <= l1_wr_address.l1.tag;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			out.op <= in.op;
			out.strand <= in.strand;
			out.address <= in.address;
			out.data <= in.data;
			out.mask <= in.mask;
			out.has_fill <= in.has_fill;
			out.fill_data <= in.fill_data;
			out.hit <= in.hit;
			out.hit_way <= in.hit_way;
			out.victim_way <= in.victim_way;
			out.victim_tag <= in.victim_tag;
			out.victim_dirty <= dirty_mem[{in.victim_way, in.address.l2.set}];
			out.l1_holders <= holders;
		end
	end

	assign out.sync_ok = 1'b0;
endmodule

`default_nettype wire

// File: logic/l2_tag_stage.sv
// Tag lookup stage with tag and valid arrays, way hit compare and victim pointers
`default_nettype none

module l2_tag_stage #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2,
	localparam int TOTAL_STRANDS = NUM_CORES * STRANDS_PER_CORE,
	localparam int STRAND_BITS = (TOTAL_STRANDS > 1) ? $clog2(TOTAL_STRANDS) : 1
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic req_valid,
	input l2_req_pkg::op_e req_op,
	input logic [STRAND_BITS-1:0] req_strand,
	input l2_req_pkg::line_addr_u req_address,
	input logic [l2_config_pkg::LINE_BITS-1:0] req_data,
	input logic [l2_config_pkg::MASK_BITS-1:0] req_mask,
	input logic req_has_fill,
	input logic [l2_config_pkg::LINE_BITS-1:0] req_fill_data,
	input logic tag_wr_en,
	input logic [l2_config_pkg::L2_INDEX_BITS-1:0] tag_wr_index,
	input logic [l2_config_pkg::L2_TAG_BITS-1:0] tag_wr_tag,
	l2_stage_if.producer out
);
	localparam int WAYS = l2_config_pkg::L2_WAYS;
	localparam int SETS = l2_config_pkg::L2_SETS;
	localparam int WAY_BITS = l2_config_pkg::L2_WAY_BITS;
	localparam int SET_BITS = l2_config_pkg::L2_SET_BITS;

	// Arrays are indexed by {way, set}
	logic [l2_config_pkg::L2_TAG_BITS-1:0] tag_mem [WAYS*SETS];
	logic [WAYS*SETS-1:0] valid_mem;
	logic [WAY_BITS-1:0] victim_ptr [SETS];

	logic [SET_BITS-1:0] set;
	logic [WAYS-1:0] way_hit;
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] victim;

	assign set = req_address.l2.set;
	assign victim = victim_ptr[set];

	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++)
		begin
			way_hit[w] = valid_mem[{w[WAY_BITS-1:0], set}]
				&& tag_mem[{w[WAY_BITS-1:0], set}] == req_address.l2.tag;
			if (way_hit[w])
				hit_way = w[WAY_BITS-1:0];
		end
	end

	// A fill installs its tag and moves the round-robin pointer of that set
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_mem <= '0;
			for (int i = 0; i < WAYS*SETS; i++)
				tag_mem[i] <= '0;
			for (int s = 0; s < SETS; s++)
				victim_ptr[s] <= '0;
		end
		else if (!stall && tag_wr_en)
		begin
			tag_mem[tag_wr_index] <= tag_wr_tag;
			valid_mem[tag_wr_index] <= 1'b1;
			victim_ptr[tag_wr_index[SET_BITS-1:0]] <= victim_ptr[tag_wr_index[SET_BITS-1:0]] + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out.valid <= 1'b0;
		else if (!stall)
			out.valid <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			out.op <= req_op;
			out.strand <= req_strand;
			out.address <= req_address;
			out.data <= req_data;
			out.mask <= req_mask;
			out.has_fill <= req_has_fill;
			out.fill_data <= req_fill_data;
			out.hit <= |way_hit;
			out.hit_way <= hit_way;
			out.victim_way <= victim;
			out.victim_tag <= tag_mem[{victim, set}];
		end
	end

	// Filled in by later stages
	assign out.victim_dirty = 1'b0;
	assign out.l1_holders = '0;
	assign out.sync_ok = 1'b0;

	// Tags are only installed after a miss, so no address lives in two ways
	a_one_way_hit: assert property (@(posedge clk) disable iff (!arst_n)
		req_valid |-> $onehot0(way_hit));
endmodule

`default_nettype wire

// File: logic/l2_stage_if.sv
// Stage-to-stage bundle with one request and its lookup results
`default_nettype none

interface l2_stage_if #(
	parameter int NUM_CORES = 2,
	parameter int STRANDS_PER_CORE = 2
);
	localparam int TOTAL_STRANDS = NUM_CORES * STRANDS_PER_CORE;
	localparam int STRAND_BITS = (TOTAL_STRANDS > 1) ? $clog2(TOTAL_STRANDS) : 1;

	// Request as it entered the pipeline
	logic valid;
	l2_req_pkg::op_e op;
	logic [STRAND_BITS-1:0] strand;
	l2_req_pkg::line_addr_u address;
	logic [l2_config_pkg::LINE_BITS-1:0] data;
	logic [l2_config_pkg::MASK_BITS-1:0] mask;
	logic has_fill;
	logic [l2_config_pkg::LINE_BITS-1:0] fill_data;

	// Results gathered on the way down
	logic hit;
	logic [l2_config_pkg::L2_WAY_BITS-1:0] hit_way;
	logic [l2_config_pkg::L2_WAY_BITS-1:0] victim_way;
	logic [l2_config_pkg::L2_TAG_BITS-1:0] victim_tag;
	logic victim_dirty;
	logic [NUM_CORES-1:0] l1_holders;
	logic sync_ok;

	modport producer (
		output valid, op, strand, address, data, mask, has_fill, fill_data,
		output hit, hit_way, victim_way, victim_tag, victim_dirty, l1_holders, sync_ok
	);

	modport consumer (
		input valid, op, strand, address, data, mask, has_fill, fill_data,
		input hit, hit_way, victim_way, victim_tag, victim_dirty, l1_holders, sync_ok
	);
endinterface

`default_nettype wire

// File: logic/l2_req_pkg.sv
// Request operation codes, the line address union and response status
`default_nettype none

package l2_req_pkg;

	typedef enum logic [1:0] {
		OP_LOAD = 2'd0,
		OP_STORE = 2'd1,
		OP_LOAD_SYNC = 2'd2,
		OP_STORE_SYNC = 2'd3
	} op_e;

	// Same 16 bits, seen by the L2 tag array or by the L1 tag copies
	typedef union packed {
		struct packed {
			logic [l2_config_pkg::L2_TAG_BITS-1:0] tag;
			logic [l2_config_pkg::L2_SET_BITS-1:0] set;
		} l2;
		struct packed {
			logic [l2_config_pkg::L1_TAG_BITS-1:0] tag;
			logic [l2_config_pkg::L1_SET_BITS-1:0] set;
		} l1;
	} line_addr_u;

	typedef enum logic {
		ST_MISS = 1'b0,
		ST_HIT = 1'b1
	} status_e;

endpackage

`default_nettype wire

// File: logic/l2_config_pkg.sv
// Cache geometry constants and the widths derived from them
`default_nettype none

package l2_config_pkg;

	// Line layout
	localparam int LINE_WORDS = 4;
	localparam int LINE_BITS = LINE_WORDS * 32;
	localparam int MASK_BITS = LINE_BITS / 8;

	// L2 organisation
	localparam int L2_WAYS = 4;
	localparam int L2_SETS = 16;
	localparam int L2_WAY_BITS = $clog2(L2_WAYS);
	localparam int L2_SET_BITS = $clog2(L2_SETS);
	localparam int L2_INDEX_BITS = L2_WAY_BITS + L2_SET_BITS;

	// Line address, split two ways by the L2 and by the L1 copies
	localparam int ADDR_BITS = 16;
	localparam int L2_TAG_BITS = ADDR_BITS - L2_SET_BITS;

	localparam int L1_SET_BITS = 3;
	localparam int L1_SETS = 1 << L1_SET_BITS;
	localparam int L1_TAG_BITS = ADDR_BITS - L1_SET_BITS;

endpackage

`default_nettype wire
